//--- mipsConsts.svh
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

// Boot ROM entry point, first fetch after reset
`define RESET_VECTOR 32'hBFC00000

// Fetching from this address stops the processor
`define HALT_ADDRESS 32'h00000000

// Architectural register file size
`define REG_COUNT 32

// Return value register, exposed for debug
`define REG_V0 5'd2

// Link register written by JAL
`define REG_RA 5'd31

// Byte lanes of one bus word
`define WORD_BYTES 4

// Offset from a jump to its return point, past the delay slot
`define LINK_OFFSET 32'd8

`endif

//--- isaPkg.sv
package isaPkg;

    // Primary opcodes of the supported instructions
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'b000000,
        OP_J       = 6'b000010,
        OP_JAL     = 6'b000011,
        OP_BEQ     = 6'b000100,
        OP_BNE     = 6'b000101,
        OP_ADDIU   = 6'b001001,
        OP_SLTI    = 6'b001010,
        OP_SLTIU   = 6'b001011,
        OP_ANDI    = 6'b001100,
        OP_ORI     = 6'b001101,
        OP_XORI    = 6'b001110,
        OP_LUI     = 6'b001111,
        OP_LB      = 6'b100000,
        OP_LW      = 6'b100011,
        OP_LBU     = 6'b100100,
        OP_SB      = 6'b101000,
        OP_SW      = 6'b101011
    } opcode_t;

    // Function field of SPECIAL instructions
    typedef enum logic [5:0] {
        FN_SLL  = 6'b000000,
        FN_SRL  = 6'b000010,
        FN_SRA  = 6'b000011,
        FN_JR   = 6'b001000,
        FN_ADDU = 6'b100001,
        FN_SUBU = 6'b100011,
        FN_AND  = 6'b100100,
        FN_OR   = 6'b100101,
        FN_XOR  = 6'b100110,
        FN_SLT  = 6'b101010,
        FN_SLTU = 6'b101011
    } func_t;

    typedef struct packed {
        logic [4:0] rd;
        logic [4:0] shamt;
        func_t      func;
    } rFields_t;

    // Low half is either the R-type fields or the 16-bit immediate
    typedef union packed {
        rFields_t    r;
        logic [15:0] immediate;
    } lowHalf_t;

    typedef struct packed {
        opcode_t    opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        lowHalf_t   low;
    } instrFields_t;

endpackage

//--- cpuPkg.sv
package cpuPkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regIndex_t;

    typedef enum logic [2:0] {
        FETCH     = 3'd0,
        DECODE    = 3'd1,
        EXEC      = 3'd2,
        MEM       = 3'd3,
        WRITEBACK = 3'd4,
        HALTED    = 3'd7
    } state_t;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLT  = 4'd5,
        ALU_SLTU = 4'd6,
        ALU_SLL  = 4'd7,
        ALU_SRL  = 4'd8,
        ALU_SRA  = 4'd9,
        ALU_LUI  = 4'd10
    } aluOp_t;

    typedef enum logic [1:0] {
        MEM_NONE, MEM_WORD, MEM_BYTE_SIGNED, MEM_BYTE_UNSIGNED
    } memKind_t;

    typedef enum logic [1:0] {B_REG, B_SIGN_IMM, B_ZERO_IMM} bSrc_t;

    typedef enum logic [1:0] {RES_ALU, RES_LOAD, RES_LINK} resSrc_t;

    typedef enum logic [2:0] {BR_NONE, BR_EQ, BR_NE, BR_JUMP, BR_REG} branchKind_t;

    // Decoded instruction, held from DECODE to WRITEBACK
    typedef struct packed {
        aluOp_t      aluOp;
        bSrc_t       bSrc;
        logic [4:0]  shamt;
        word_t       imm;
        logic        regWrite;
        regIndex_t   regDest;
        resSrc_t     resultSrc;
        logic        memRead;
        logic        memWrite;
        memKind_t    memKind;
        branchKind_t branch;
        logic [25:0] jumpIndex;
    } control_t;

    typedef struct packed {
        word_t      address;
        logic [3:0] byteEnable;
        logic       read;
        logic       write;
        word_t      writeData;
    } busReq_t;

endpackage

//--- instrDecoder.sv
`timescale 1ns/100ps

module instrDecoder (
    input  isaPkg::instrFields_t instr,
    output cpuPkg::control_t     ctrl
);
    import isaPkg::*;
    import cpuPkg::*;

    always_comb begin
        ctrl = '0;
        ctrl.aluOp = ALU_ADD;
        ctrl.bSrc = B_REG;
        ctrl.shamt = instr.low.r.shamt;
        ctrl.imm = {{16{instr.low.immediate[15]}}, instr.low.immediate};
        ctrl.regDest = instr.rt;
        ctrl.resultSrc = RES_ALU;
        ctrl.memKind = MEM_NONE;
        ctrl.branch = BR_NONE;
        ctrl.jumpIndex = {instr.rs, instr.rt, instr.low.immediate};

        case (instr.opcode)
            OP_SPECIAL: begin
                ctrl.regDest = instr.low.r.rd;
                ctrl.regWrite = 1'b1;
                case (instr.low.r.func)
                    FN_ADDU: ctrl.aluOp = ALU_ADD;
                    FN_SUBU: ctrl.aluOp = ALU_SUB;
                    FN_AND:  ctrl.aluOp = ALU_AND;
                    FN_OR:   ctrl.aluOp = ALU_OR;
                    FN_XOR:  ctrl.aluOp = ALU_XOR;
                    FN_SLT:  ctrl.aluOp = ALU_SLT;
                    FN_SLTU: ctrl.aluOp = ALU_SLTU;
                    FN_SLL:  ctrl.aluOp = ALU_SLL;
                    FN_SRL:  ctrl.aluOp = ALU_SRL;
                    FN_SRA:  ctrl.aluOp = ALU_SRA;
                    FN_JR: begin
                        ctrl.regWrite = 1'b0;
                        ctrl.branch = BR_REG;
                    end
                    default: ctrl.regWrite = 1'b0;
                endcase
            end
            OP_ADDIU, OP_SLTI, OP_SLTIU: begin
                ctrl.bSrc = B_SIGN_IMM;
                ctrl.regWrite = 1'b1;
                if (instr.opcode == OP_SLTI) begin
                    ctrl.aluOp = ALU_SLT;
                end else if (instr.opcode == OP_SLTIU) begin
                    ctrl.aluOp = ALU_SLTU;
                end
            end
            OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                ctrl.bSrc = B_ZERO_IMM;
                ctrl.regWrite = 1'b1;
                case (instr.opcode)
                    OP_ANDI: ctrl.aluOp = ALU_AND;
                    OP_ORI:  ctrl.aluOp = ALU_OR;
                    OP_XORI: ctrl.aluOp = ALU_XOR;
                    default: ctrl.aluOp = ALU_LUI;
                endcase
            end
            OP_LW, OP_LB, OP_LBU: begin
                ctrl.bSrc = B_SIGN_IMM;
                ctrl.regWrite = 1'b1;
                ctrl.resultSrc = RES_LOAD;
                ctrl.memRead = 1'b1;
                ctrl.memKind = (instr.opcode == OP_LW) ? MEM_WORD :
                               (instr.opcode == OP_LB) ? MEM_BYTE_SIGNED : MEM_BYTE_UNSIGNED;
            end
            OP_SW, OP_SB: begin
                ctrl.bSrc = B_SIGN_IMM;
                ctrl.memWrite = 1'b1;
                ctrl.memKind = (instr.opcode == OP_SW) ? MEM_WORD : MEM_BYTE_UNSIGNED;
            end
            // Compare by subtraction, zero flag decides
            OP_BEQ, OP_BNE: begin
                ctrl.aluOp = ALU_SUB;
                ctrl.branch = (instr.opcode == OP_BEQ) ? BR_EQ : BR_NE;
            end
            OP_J: ctrl.branch = BR_JUMP;
            OP_JAL: begin
                ctrl.branch = BR_JUMP;
                ctrl.regWrite = 1'b1;
                ctrl.resultSrc = RES_LINK;
            end
            default: ctrl.regWrite = 1'b0;
        endcase
    end

endmodule

//--- regFile.sv
`timescale 1ns/100ps
`include "mipsConsts.svh"

module regFile (
    input  logic              clk,
    input  logic              reset,
    input  logic              write,
    input  cpuPkg::regIndex_t wrAddr,
    input  cpuPkg::word_t     wrData,
    input  cpuPkg::regIndex_t rdAddrA,
    output cpuPkg::word_t     rdDataA,
    input  cpuPkg::regIndex_t rdAddrB,
    output cpuPkg::word_t     rdDataB,
    output cpuPkg::word_t     registerV0
);
    import cpuPkg::*;

    word_t regs [`REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (write && wrAddr != '0) begin
            // Register zero is hardwired
            regs[wrAddr] <= wrData;
        end
    end

    assign rdDataA = regs[rdAddrA];
    assign rdDataB = regs[rdAddrB];
    assign registerV0 = regs[`REG_V0];

endmodule

//--- alu.sv
`timescale 1ns/100ps

module alu (
    input  cpuPkg::aluOp_t op,
    input  cpuPkg::word_t  a,
    input  cpuPkg::word_t  b,
    input  logic [4:0]     shamt,
    output cpuPkg::word_t  result,
    output logic           zero
);
    import cpuPkg::*;

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            ALU_SLT:  result = {31'b0, $signed(a) < $signed(b)};
            ALU_SLTU: result = {31'b0, a < b};
            // Fixed shifts act on the rt operand
            ALU_SLL:  result = b << shamt;
            ALU_SRL:  result = b >> shamt;
            ALU_SRA:  result = $signed(b) >>> shamt;
            ALU_LUI:  result = {b[15:0], 16'b0};
            default:  result = '0;
        endcase
    end

    assign zero = (result == '0);

endmodule

//--- memPort.sv
`timescale 1ns/100ps

module memPort (
    input  cpuPkg::control_t ctrl,
    input  cpuPkg::word_t    effAddress,
    input  cpuPkg::word_t    storeData,
    input  cpuPkg::word_t    readData,
    output cpuPkg::busReq_t  lanes,
    output cpuPkg::word_t    loadData
);
    import cpuPkg::*;

    logic [1:0] lane;
    logic [7:0] loadByte;

    assign lane = effAddress[1:0];

    // Request for the data phase
    always_comb begin
        lanes = '0;
        lanes.address = {effAddress[31:2], 2'b00};
        lanes.read = ctrl.memRead;
        lanes.write = ctrl.memWrite;
        case (ctrl.memKind)
            MEM_WORD: begin
                lanes.byteEnable = 4'b1111;
                lanes.writeData = storeData;
            end
            MEM_BYTE_SIGNED, MEM_BYTE_UNSIGNED: begin
                lanes.byteEnable = 4'b0001 << lane;
                // Same byte on every lane, enables pick the one written
                lanes.writeData = {4{storeData[7:0]}};
            end
            default: begin
                lanes.byteEnable = 4'b0000;
                lanes.writeData = '0;
            end
        endcase
    end

    assign loadByte = readData[{lane, 3'b000} +: 8];

    always_comb begin
        case (ctrl.memKind)
            MEM_BYTE_SIGNED:   loadData = {{24{loadByte[7]}}, loadByte};
            MEM_BYTE_UNSIGNED: loadData = {24'b0, loadByte};
            default:           loadData = readData;
        endcase
    end

endmodule

//--- cpuController.sv
`timescale 1ns/100ps
`include "mipsConsts.svh"

module cpuController (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 waitrequest,
    input  cpuPkg::word_t        readData,
    output isaPkg::instrFields_t instr,
    input  cpuPkg::control_t     decoded,
    output cpuPkg::control_t     ctrl,
    input  cpuPkg::word_t        rsData,
    input  logic                 aluZero,
    input  cpuPkg::word_t        aluResult,
    input  cpuPkg::word_t        loadData,
    input  cpuPkg::busReq_t      dataLanes,
    output cpuPkg::busReq_t      bus,
    output logic                 regWrite,
    output cpuPkg::regIndex_t    regDest,
    output cpuPkg::word_t        regData,
    output logic                 active
);
    import cpuPkg::*;
    import isaPkg::*;

    state_t     state;
    word_t      pc;
    word_t      pcPlus4;
    word_t      branchTarget;
    word_t      loadReg;
    logic [1:0] delayCount;
    logic       fetchHalt;
    logic       memAccess;
    logic       takeBranch;

    assign pcPlus4 = pc + 32'd4;
    assign fetchHalt = (state == FETCH) && (pc == `HALT_ADDRESS);
    assign memAccess = ctrl.memRead || ctrl.memWrite;

    always_comb begin
        case (ctrl.branch)
            BR_EQ:           takeBranch = aluZero;
            BR_NE:           takeBranch = !aluZero;
            BR_JUMP, BR_REG: takeBranch = 1'b1;
            default:         takeBranch = 1'b0;
        endcase
    end

    // Fetch request, data request or an idle bus
    always_comb begin
        bus = '0;
        if (state == FETCH && !fetchHalt) begin
            bus.address = {pc[31:2], 2'b00};
            bus.byteEnable = 4'b1111;
            bus.read = 1'b1;
        end else if (state == MEM && memAccess) begin
            bus = dataLanes;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FETCH;
            pc <= `RESET_VECTOR;
            active <= 1'b1;
            delayCount <= 2'd0;
            ctrl <= '0;
        end else begin
            case (state)
                FETCH: begin
                    if (fetchHalt) begin
                        state <= HALTED;
                        active <= 1'b0;
                    end else if (!waitrequest) begin
                        state <= DECODE;
                    end
                end
                DECODE: begin
                    ctrl <= decoded;
                    state <= EXEC;
                end
                EXEC: begin
                    if (takeBranch) begin
                        delayCount <= 2'd1;
                    end
                    state <= MEM;
                end
                MEM: begin
                    if (!memAccess || !waitrequest) begin
                        state <= WRITEBACK;
                    end
                end
                WRITEBACK: begin
                    state <= FETCH;
                    // Step 1 runs the delay slot, step 2 jumps
                    if (delayCount == 2'd2) begin
                        delayCount <= 2'd0;
                        pc <= branchTarget;
                    end else begin
                        delayCount <= (delayCount == 2'd1) ? 2'd2 : 2'd0;
                        pc <= pcPlus4;
                    end
                end
                default: state <= HALTED;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == FETCH && !fetchHalt && !waitrequest) begin
            instr <= instrFields_t'(readData);
        end
        if (state == EXEC && takeBranch) begin
            case (ctrl.branch)
                BR_JUMP: branchTarget <= {pcPlus4[31:28], ctrl.jumpIndex, 2'b00};
                BR_REG:  branchTarget <= rsData;
                default: branchTarget <= pcPlus4 + {ctrl.imm[29:0], 2'b00};
            endcase
        end
        if (state == MEM && ctrl.memRead && !waitrequest) begin
            loadReg <= loadData;
        end
    end

    assign regWrite = (state == WRITEBACK) && ctrl.regWrite;
    assign regDest = (ctrl.resultSrc == RES_LINK) ? `REG_RA : ctrl.regDest;

    always_comb begin
        case (ctrl.resultSrc)
            RES_LOAD: regData = loadReg;
            RES_LINK: regData = pc + `LINK_OFFSET;
            default:  regData = aluResult;
        endcase
    end

endmodule

//--- mipsCpuBus.sv
`timescale 1ns/100ps

module mipsCpuBus (
    input  logic          clk,
    input  logic          reset,
    output logic          active,
    output cpuPkg::word_t registerV0,
    output cpuPkg::word_t address,
    output logic          write,
    output logic          read,
    input  logic          waitrequest,
    output cpuPkg::word_t writeData,
    output logic [3:0]    byteEnable,
    input  cpuPkg::word_t readData
);
    import cpuPkg::*;
    import isaPkg::*;

    instrFields_t instr;
    control_t     decoded;
    control_t     ctrl;
    busReq_t      bus;
    busReq_t      dataLanes;
    word_t        rsData;
    word_t        rtData;
    word_t        aluB;
    word_t        aluResult;
    word_t        loadData;
    word_t        regData;
    regIndex_t    regDest;
    logic         regWrite;
    logic         aluZero;

    always_comb begin
        case (ctrl.bSrc)
            B_SIGN_IMM: aluB = ctrl.imm;
            B_ZERO_IMM: aluB = {16'b0, ctrl.imm[15:0]};
            default:    aluB = rtData;
        endcase
    end

    assign address = bus.address;
    assign byteEnable = bus.byteEnable;
    assign read = bus.read;
    assign write = bus.write;
    assign writeData = bus.writeData;

    cpuController controller_i (
        .clk(clk), .reset(reset), .waitrequest(waitrequest), .readData(readData),
        .instr(instr), .decoded(decoded), .ctrl(ctrl), .rsData(rsData),
        .aluZero(aluZero), .aluResult(aluResult), .loadData(loadData),
        .dataLanes(dataLanes), .bus(bus), .regWrite(regWrite), .regDest(regDest),
        .regData(regData), .active(active)
    );

    instrDecoder decoder_i (.instr(instr), .ctrl(decoded));

    regFile regFile_i (
        .clk(clk), .reset(reset), .write(regWrite), .wrAddr(regDest), .wrData(regData),
        .rdAddrA(instr.rs), .rdDataA(rsData), .rdAddrB(instr.rt), .rdDataB(rtData),
        .registerV0(registerV0)
    );

    alu alu_i (
        .op(ctrl.aluOp), .a(rsData), .b(aluB), .shamt(ctrl.shamt),
        .result(aluResult), .zero(aluZero)
    );

    memPort memPort_i (
        .ctrl(ctrl), .effAddress(aluResult), .storeData(rtData), .readData(readData),
        .lanes(dataLanes), .loadData(loadData)
    );

endmodule

//--- mipsCpuBus_chk.sv
`timescale 1ns/100ps

module mipsCpuBus_chk (
    input logic          clk,
    input logic          reset,
    input logic          active,
    input cpuPkg::word_t address,
    input logic          read,
    input logic          write,
    input logic [3:0]    byteEnable
);

    // Failed assertions so far, read by the testbench
    int unsigned failures = 0;

    noReadWriteOverlap: assert property (@(posedge clk) disable iff (reset) !(read && write))
        else begin
            $error("read and write strobes are high in the same cycle");
            failures++;
        end

    lanesOnStrobe: assert property (@(posedge clk) disable iff (reset)
        (read || write) |-> byteEnable != 4'b0000)
        else begin
            $error("bus strobe with no byte lane enabled");
            failures++;
        end

    wordAligned: assert property (@(posedge clk) disable iff (reset) address[1:0] == 2'b00)
        else begin
            $error("bus address %h is not word aligned", address);
            failures++;
        end

    // Once halted, only reset brings the core back
    staysHalted: assert property (@(posedge clk) (!active && !reset) |=> !active)
        else begin
            $error("active rose again without a reset");
            failures++;
        end

endmodule

//--- tbMipsCpuBus.sv
`timescale 1ns/100ps
`include "mipsConsts.svh"

module tbMipsCpuBus;
    import cpuPkg::*;

    localparam time CLK_PERIOD = 100;
    localparam int  RESET_CYCLES = 4;
    localparam int  CASE_CYCLES = 200;
    localparam int  HALT_OBSERVE = 4;

    logic       clk;
    logic       reset;
    logic       active;
    word_t      registerV0;
    word_t      address;
    logic       write;
    logic       read;
    logic       waitrequest = 1'b0;
    word_t      writeData;
    logic [3:0] byteEnable;
    word_t      readData = '0;

    // Bus memory, keyed by word address
    word_t mem [word_t];
    word_t lcgState = 32'h3fd8_3e31;
    int    waitLeft = -1;

    int    fd;
    int    watchdogCycles = 0;
    int    casesRun = 0;
    string caseName;
    word_t expV0;
    word_t expAddrs [$];
    word_t expValues [$];

    mipsCpuBus dut_i (
        .clk(clk), .reset(reset), .active(active), .registerV0(registerV0),
        .address(address), .write(write), .read(read), .waitrequest(waitrequest),
        .writeData(writeData), .byteEnable(byteEnable), .readData(readData)
    );

    bind mipsCpuBus mipsCpuBus_chk chk_i (
        .clk(clk), .reset(reset), .active(active), .address(address),
        .read(read), .write(write), .byteEnable(byteEnable)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic word_t nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    task automatic abortRun();
        $display("Regression failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic serveBus();
        word_t stored;
        stored = mem.exists(address) ? mem[address] : '0;
        if (read) begin
            readData = stored;
        end
        if (write) begin
            for (int b = 0; b < `WORD_BYTES; b++) begin
                if (byteEnable[b]) begin
                    stored[8 * b +: 8] = writeData[8 * b +: 8];
                end
            end
            mem[address] = stored;
        end
    endtask

    // Slave side: 0 to 2 wait cycles per transfer
    always @(negedge clk) begin
        if (!(read || write)) begin
            waitrequest = 1'b0;
            waitLeft = -1;
        end else begin
            if (waitLeft < 0) begin
                waitLeft = int'(nextRandom() >> 16) % 3;
            end
            if (waitLeft > 0) begin
                waitrequest = 1'b1;
                waitLeft--;
            end else begin
                waitrequest = 1'b0;
                serveBus();
                waitLeft = -1;
            end
        end
    end

    task automatic checkReg(input word_t actual, input word_t expected);
        if (actual !== expected) begin
            $display("[FAIL] %0t: case %s, v0 is %h, expected %h",
                     $time, caseName, actual, expected);
            abortRun();
        end
    endtask

    task automatic checkMem(input word_t addr, input word_t expected);
        word_t actual;
        actual = mem.exists(addr) ? mem[addr] : '0;
        if (actual !== expected) begin
            $display("[FAIL] %0t: case %s, memory %h holds %h, expected %h",
                     $time, caseName, addr, actual, expected);
            abortRun();
        end
    endtask

    task automatic checkHalt(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            $display("[FAIL] %0t: case %s, %s is %b, expected %b",
                     $time, caseName, what, actual, expected);
            abortRun();
        end
    endtask

    task automatic verifyBusRules();
        if (dut_i.chk_i.failures != 0) begin
            $display("A bus checker assertion failed during case %s", caseName);
            abortRun();
        end
    endtask

    // Next token of the case file, comment lines skipped
    task automatic readTag(output string tag, output bit found);
        string rest;
        int    code;
        tag = "";
        code = $fscanf(fd, "%s", tag);
        while (code == 1 && tag.substr(0, 0) == "#") begin
            code = $fgets(rest, fd);
            code = $fscanf(fd, "%s", tag);
        end
        found = (code == 1);
    endtask

    task automatic runCase();
        reset = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        while (active !== 1'b0) begin
            @(negedge clk);
            verifyBusRules();
        end
        checkReg(registerV0, expV0);
        foreach (expAddrs[i]) begin
            checkMem(expAddrs[i], expValues[i]);
        end
        // Halted core stays inactive and leaves the bus idle
        repeat (HALT_OBSERVE) begin
            @(negedge clk);
            checkHalt(active, 1'b0, "active");
            checkHalt(read || write, 1'b0, "bus strobe");
            verifyBusRules();
        end
        casesRun++;
    endtask

    initial begin
        wait (watchdogCycles > 0);
        #(watchdogCycles * CLK_PERIOD);
        $display("Timeout: the processor never halted within %0d cycles", watchdogCycles);
        abortRun();
    end

    initial begin
        string tag;
        bit    found;
        word_t addr;
        word_t value;
        int    count;
        int    code;
        int    numCases;

        reset = 1'b1;
        numCases = 0;
        fd = $fopen("programCases.txt", "r");
        if (fd == 0) begin
            $display("Could not open programCases.txt");
            abortRun();
        end
        // First pass only sizes the watchdog
        readTag(tag, found);
        while (found) begin
            if (tag == "case") begin
                numCases++;
            end
            readTag(tag, found);
        end
        $fclose(fd);
        if (numCases == 0) begin
            $display("No cases found in programCases.txt");
            abortRun();
        end
        watchdogCycles = numCases * CASE_CYCLES;

        fd = $fopen("programCases.txt", "r");
        readTag(tag, found);
        while (found) begin
            if (tag == "case") begin
                code = $fscanf(fd, "%s", caseName);
                mem.delete();
                expAddrs.delete();
                expValues.delete();
            end else if (tag == "code") begin
                code = $fscanf(fd, "%h %d", addr, count);
                for (int i = 0; i < count; i++) begin
                    code = $fscanf(fd, "%h", value);
                    mem[addr + `WORD_BYTES * i] = value;
                end
            end else if (tag == "mem") begin
                code = $fscanf(fd, "%h %h", addr, value);
                mem[addr] = value;
            end else if (tag == "v0") begin
                code = $fscanf(fd, "%h", expV0);
            end else if (tag == "expect") begin
                code = $fscanf(fd, "%h %h", addr, value);
                expAddrs.push_back(addr);
                expValues.push_back(value);
            end else if (tag == "end") begin
                runCase();
            end else begin
                $display("Unknown entry %s in programCases.txt", tag);
                abortRun();
            end
            readTag(tag, found);
        end
        $fclose(fd);
        $display("Ran %0d cases", casesRun);
        $display("Regression passed");
        $finish;
    end

endmodule

//--- programCases.txt
# case <name> | code <addr> <count> <words...> | mem <addr> <word>
# v0 <expected v0> | expect <addr> <expected word> | end runs the case
case aluChain
code bfc00000 22
3c088000 350800f0 00084903 00085102 000a58c0 392900ff 016a1023 012a602a
012a682b 292effff 2d4fffff 30480f0f 00481021 004c1021 004d1021 000e7100
004e1021 000f7a00 004f1021 2442fffd 00000008 00000000
v0 38000180
end
case storeLoadWord
mem 00000100 12345678
code bfc00000 7
3c08cafe 3508f00d ac080100 8c020100 24420001 00000008 00000000
v0 cafef00e
expect 00000100 cafef00d
end
case byteLanes
mem 00000200 7f80a55a
mem 00000210 11223344
code bfc00000 21
240901cc a0090211 80020211
80080200 ac080300 80080201 ac080304 80080202 ac080308 80080203 ac08030c
90080200 ac080310 90080201 ac080314 90080202 ac080318 90080203 ac08031c
00000008 00000000
v0 ffffffcc
expect 00000210 1122cc44 expect 00000200 7f80a55a
expect 00000300 0000005a expect 00000304 ffffffa5
expect 00000308 ffffff80 expect 0000030c 0000007f
expect 00000310 0000005a expect 00000314 000000a5
expect 00000318 00000080 expect 0000031c 0000007f
end
case branchDelaySlots
code bfc00000 13
24020000 24080005 11000003 24420001 24420010 15000002 24420100 24421000
11080002 24420002 24424000 00000008 00000000
v0 00000113
end
case jalReturn
code bfc00000 6
24020007 0ff00010 24420010 24420100 00000008 00000000
code bfc00040 3
ac1f0400 03e00008 24421000
v0 00001117
expect 00000400 bfc0000c
end

//--- all.f
+incdir+.
isaPkg.sv
cpuPkg.sv
instrDecoder.sv
regFile.sv
alu.sv
memPort.sv
cpuController.sv
mipsCpuBus.sv
mipsCpuBus_chk.sv
tbMipsCpuBus.sv

//--- Bender.yml
package:
  name: mipsCpuBus

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - isaPkg.sv
      - cpuPkg.sv
      - instrDecoder.sv
      - regFile.sv
      - alu.sv
      - memPort.sv
      - cpuController.sv
      - mipsCpuBus.sv
  - target: test
    include_dirs:
      - .
    files:
      - mipsCpuBus_chk.sv
      - tbMipsCpuBus.sv
